// ==== armCore.f ====
+incdir+include
hw/armCorePkg.sv
hw/alu.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/hazardUnit.sv
hw/armCore.sv
test/storeChecker.sv
test/tb_armCore.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  armCorePkg::aluOp_t op,
    input  armCorePkg::word_t  srcA,
    input  armCorePkg::word_t  srcB,
    output armCorePkg::word_t  result
);

    // No flags are kept, so results simply wrap
    always_comb begin
        case (op)
            armCorePkg::aluAdd: result = srcA + srcB;
            armCorePkg::aluSub: result = srcA - srcB;
            armCorePkg::aluAnd: result = srcA & srcB;
            armCorePkg::aluOrr: result = srcA | srcB;
            default:            result = srcB;
        endcase
    end

endmodule

// ==== hw/armCore.sv ====
`timescale 1ns/1ns
`include "armCore_config.svh"

module armCore (
    input  logic              CLK,
    input  logic              rstN,
    input  armCorePkg::word_t instr,
    input  armCorePkg::word_t dataRead,
    output armCorePkg::word_t pc,
    output armCorePkg::word_t dataAddr,
    output armCorePkg::word_t dataWriteData,
    output logic              dataWe
);

    armCorePkg::word_t       pcPlus4;
    armCorePkg::word_t       instrD;

    armCorePkg::ctrl_t       ctrlD;
    armCorePkg::regAddr_t    ra1D;
    armCorePkg::regAddr_t    ra2D;
    armCorePkg::regAddr_t    wa3D;
    armCorePkg::word_t       extImmD;
    armCorePkg::word_t       rd1D;
    armCorePkg::word_t       rd2D;

    armCorePkg::decExe_t     exe;
    armCorePkg::exeMem_t     mem;
    armCorePkg::memWb_t      wb;

    armCorePkg::forwardSel_t forwardA;
    armCorePkg::forwardSel_t forwardB;
    logic                    forwardStore;
    logic                    stallF;
    logic                    stallD;
    logic                    flushD;
    logic                    flushE;

    armCorePkg::word_t       srcA;
    armCorePkg::word_t       srcBReg;
    armCorePkg::word_t       srcB;
    armCorePkg::word_t       aluResult;
    armCorePkg::word_t       resultW;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    assign pcPlus4 = pc + 32'd4;

    // Taken branch resolves in execute
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= `RESET_PC;
        end else if (exe.ctrl.branch) begin
            pc <= aluResult;
        end else if (!stallF) begin
            pc <= pcPlus4;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN || flushD) begin
            instrD <= `BUBBLE_INSTR;
        end else if (!stallD) begin
            instrD <= instr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    instrDecoder i_instrDecoder (
        .instrD (instrD),
        .ctrl   (ctrlD),
        .ra1    (ra1D),
        .ra2    (ra2D),
        .wa3    (wa3D),
        .extImm (extImmD)
    );

    // Fetch PC+4 is decode PC+8
    registerFile i_registerFile (
        .CLK  (CLK),
        .rstN (rstN),
        .we   (wb.regWrite),
        .ra1  (ra1D),
        .ra2  (ra2D),
        .wa3  (wb.wa3),
        .wd3  (resultW),
        .r15  (pcPlus4),
        .rd1  (rd1D),
        .rd2  (rd2D)
    );

    hazardUnit i_hazardUnit (
        .ra1D         (ra1D),
        .ra2D         (ra2D),
        .exe          (exe),
        .mem          (mem),
        .wa3W         (wb.wa3),
        .regWriteW    (wb.regWrite),
        .branchE      (exe.ctrl.branch),
        .forwardA     (forwardA),
        .forwardB     (forwardB),
        .forwardStore (forwardStore),
        .stallF       (stallF),
        .stallD       (stallD),
        .flushD       (flushD),
        .flushE       (flushE)
    );

    // Flush or load-use stall leaves a bubble in execute
    always_ff @(posedge CLK) begin
        exe.rd1    <= rd1D;
        exe.rd2    <= rd2D;
        exe.extImm <= extImmD;
        exe.ra1    <= ra1D;
        exe.ra2    <= ra2D;
        exe.wa3    <= wa3D;
        if (!rstN || flushE) begin
            exe.ctrl <= '0;
        end else begin
            exe.ctrl <= ctrlD;
        end
    end

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (forwardA)
            armCorePkg::fromMem: srcA = mem.aluOut;
            armCorePkg::fromWb:  srcA = resultW;
            default:             srcA = exe.rd1;
        endcase
    end

    always_comb begin
        case (forwardB)
            armCorePkg::fromMem: srcBReg = mem.aluOut;
            armCorePkg::fromWb:  srcBReg = resultW;
            default:             srcBReg = exe.rd2;
        endcase
    end

    assign srcB = exe.ctrl.aluSrcImm ? exe.extImm : srcBReg;

    alu i_alu (
        .op     (exe.ctrl.aluOp),
        .srcA   (srcA),
        .srcB   (srcB),
        .result (aluResult)
    );

    always_ff @(posedge CLK) begin
        mem.aluOut    <= aluResult;
        mem.writeData <= srcBReg;
        mem.ra2       <= exe.ra2;
        mem.wa3       <= exe.wa3;
        if (!rstN) begin
            mem.regWrite <= 1'b0;
            mem.memWrite <= 1'b0;
            mem.memToReg <= 1'b0;
        end else begin
            mem.regWrite <= exe.ctrl.regWrite;
            mem.memWrite <= exe.ctrl.memWrite;
            mem.memToReg <= exe.ctrl.memToReg;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory
    ////////////////////////////////////////////////////////////

    assign dataAddr      = mem.aluOut;
    assign dataWriteData = forwardStore ? resultW : mem.writeData;
    assign dataWe        = mem.memWrite;

    always_ff @(posedge CLK) begin
        wb.readData <= dataRead;
        wb.aluOut   <= mem.aluOut;
        wb.wa3      <= mem.wa3;
        if (!rstN) begin
            wb.regWrite <= 1'b0;
            wb.memToReg <= 1'b0;
        end else begin
            wb.regWrite <= mem.regWrite;
            wb.memToReg <= mem.memToReg;
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////

    assign resultW = wb.memToReg ? wb.readData : wb.aluOut;

endmodule

// ==== hw/armCorePkg.sv ====
`include "armCore_config.svh"

package armCorePkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [3:0]         regAddr_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOrr,
        aluMov
    } aluOp_t;

    typedef enum logic [1:0] {
        fromReg,
        fromWb,
        fromMem
    } forwardSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memWrite;
        logic   memToReg;
        logic   aluSrcImm;
        logic   branch;
        aluOp_t aluOp;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        ctrl_t    ctrl;
        word_t    rd1;
        word_t    rd2;
        word_t    extImm;
        regAddr_t ra1;
        regAddr_t ra2;
        regAddr_t wa3;
    } decExe_t;

    // Execute to memory
    typedef struct packed {
        logic     regWrite;
        logic     memWrite;
        logic     memToReg;
        word_t    aluOut;
        word_t    writeData;
        regAddr_t ra2;
        regAddr_t wa3;
    } exeMem_t;

    // Memory to writeback
    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        word_t    readData;
        word_t    aluOut;
        regAddr_t wa3;
    } memWb_t;

endpackage

// ==== hw/hazardUnit.sv ====
`timescale 1ns/1ns
`include "armCore_config.svh"

module hazardUnit (
    input  armCorePkg::regAddr_t    ra1D,
    input  armCorePkg::regAddr_t    ra2D,
    input  armCorePkg::decExe_t     exe,
    input  armCorePkg::exeMem_t     mem,
    input  armCorePkg::regAddr_t    wa3W,
    input  logic                    regWriteW,
    input  logic                    branchE,
    output armCorePkg::forwardSel_t forwardA,
    output armCorePkg::forwardSel_t forwardB,
    output logic                    forwardStore,
    output logic                    stallF,
    output logic                    stallD,
    output logic                    flushD,
    output logic                    flushE
);

    logic loadStall;

    // Memory stage holds the younger result
    function automatic armCorePkg::forwardSel_t pickSource(armCorePkg::regAddr_t ra);
        if (ra == `R15) begin
            return armCorePkg::fromReg;
        end
        if (mem.regWrite && mem.wa3 == ra) begin
            return armCorePkg::fromMem;
        end
        if (regWriteW && wa3W == ra) begin
            return armCorePkg::fromWb;
        end
        return armCorePkg::fromReg;
    endfunction

    always_comb forwardA = pickSource(exe.ra1);
    always_comb forwardB = pickSource(exe.ra2);

    assign forwardStore = mem.memWrite && regWriteW && wa3W == mem.ra2 && mem.ra2 != `R15;

    // Loaded data is not ready until writeback
    assign loadStall = exe.ctrl.memToReg && (exe.wa3 == ra1D || exe.wa3 == ra2D);

    assign stallF = loadStall;
    assign stallD = loadStall;
    assign flushD = branchE;
    assign flushE = branchE || loadStall;

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ns
`include "armCore_config.svh"

module instrDecoder (
    input  armCorePkg::word_t    instrD,
    output armCorePkg::ctrl_t    ctrl,
    output armCorePkg::regAddr_t ra1,
    output armCorePkg::regAddr_t ra2,
    output armCorePkg::regAddr_t wa3,
    output armCorePkg::word_t    extImm
);

    logic [1:0]           op;
    logic [3:0]           cmd;
    logic                 immForm;
    logic                 isLoad;
    armCorePkg::regAddr_t rn;
    armCorePkg::regAddr_t rd;
    armCorePkg::regAddr_t rm;

    assign op      = instrD[`OP_LSB +: 2];
    assign cmd     = instrD[`CMD_LSB +: 4];
    assign immForm = instrD[`IMM_BIT];
    assign isLoad  = instrD[`LOAD_BIT];
    assign rn      = instrD[`RN_LSB +: 4];
    assign rd      = instrD[`RD_LSB +: 4];
    assign rm      = instrD[`RM_LSB +: 4];

    // Every instruction in the subset writes Rd if it writes at all
    assign wa3 = rd;

    always_comb begin
        ctrl   = '0;
        extImm = '0;
        ra1    = rn;
        ra2    = rm;
        case (op)
            2'b00: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = immForm;
                extImm         = {24'b0, instrD[7:0]};
                case (cmd)
                    4'b0000: ctrl.aluOp = armCorePkg::aluAnd;
                    4'b0010: ctrl.aluOp = armCorePkg::aluSub;
                    4'b1100: ctrl.aluOp = armCorePkg::aluOrr;
                    4'b1101: ctrl.aluOp = armCorePkg::aluMov;
                    default: ctrl.aluOp = armCorePkg::aluAdd;
                endcase
            end
            2'b01: begin
                // Base plus unsigned offset
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = armCorePkg::aluAdd;
                ctrl.regWrite  = isLoad;
                ctrl.memToReg  = isLoad;
                ctrl.memWrite  = !isLoad;
                extImm         = {20'b0, instrD[11:0]};
                if (!isLoad) begin
                    ra2 = rd;
                end
            end
            2'b10: begin
                ctrl.branch    = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = armCorePkg::aluAdd;
                ra1            = `R15;
                extImm         = {{6{instrD[23]}}, instrD[23:0], 2'b00};
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hw/registerFile.sv ====
`timescale 1ns/1ns
`include "armCore_config.svh"

module registerFile (
    input  logic                 CLK,
    input  logic                 rstN,
    input  logic                 we,
    input  armCorePkg::regAddr_t ra1,
    input  armCorePkg::regAddr_t ra2,
    input  armCorePkg::regAddr_t wa3,
    input  armCorePkg::word_t    wd3,
    input  armCorePkg::word_t    r15,
    output armCorePkg::word_t    rd1,
    output armCorePkg::word_t    rd2
);

    armCorePkg::word_t regs [`REG_COUNT];

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa3 != `R15) begin
            regs[wa3] <= wd3;
        end
    end

    // PC read, then same-cycle write bypass
    function automatic armCorePkg::word_t readPort(armCorePkg::regAddr_t ra);
        if (ra == `R15) begin
            return r15;
        end
        if (we && ra == wa3) begin
            return wd3;
        end
        return regs[ra];
    endfunction

    always_comb rd1 = readPort(ra1);
    always_comb rd2 = readPort(ra2);

endmodule

// ==== include/armCore_config.svh ====
`ifndef ARMCORE_CONFIG_SVH
`define ARMCORE_CONFIG_SVH

// Datapath and register file
`define WORD_W      32
`define REG_COUNT   15
`define R15         4'd15
`define RESET_PC    32'h0000_0000

// Instruction word fields
`define COND_LSB    28
`define OP_LSB      (`COND_LSB - 2)
`define IMM_BIT     25
`define CMD_LSB     21
`define LOAD_BIT    20
`define RN_LSB      16
`define RD_LSB      12
`define RM_LSB      0

// Op field 2'b11 is outside the subset and decodes to no action
`define BUBBLE_INSTR 32'h0C00_0000

`endif

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the armCore testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary -j 0 --top-module tb_armCore -f armCore.f -Mdir obj_dir &&
./obj_dir/Vtb_armCore | tee /dev/stderr | grep -q ">>> PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

// ==== test/storeChecker.sv ====
`timescale 1ns/1ns
`include "armCore_config.svh"

module storeChecker (
    input  logic               CLK,
    input  logic               rstN,
    input  logic [63:0][31:0]  programImage,
    input  logic [255:0][31:0] dataImage,
    input  armCorePkg::word_t  pc,
    input  logic               dataWe,
    input  armCorePkg::word_t  dataAddr,
    input  armCorePkg::word_t  dataWriteData,
    output int                 errorCount,
    output int                 storeCount,
    output int                 expectedCount,
    output logic               done
);

    localparam logic [31:0] FinalPc     = 32'(63 * 4);
    localparam int          DrainCycles = 20;

    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          settledCycles;

    // Instruction-set model stepping one instruction at a time
    function automatic void runReference();
        logic [31:0] regs [16];
        logic [31:0] dmemRef [256];
        logic [31:0] pcRef;
        logic [31:0] ir;
        logic [31:0] opB;
        logic [31:0] addr;
        logic [31:0] result;
        logic [3:0]  rn;
        logic [3:0]  rd;
        int          steps;
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmemRef[i] = dataImage[i];
        end
        pcRef = `RESET_PC;
        steps = 0;
        while (pcRef != FinalPc && steps < 1000) begin
            ir       = programImage[pcRef[7:2]];
            rn       = ir[19:16];
            rd       = ir[15:12];
            regs[15] = pcRef + 32'd8;
            steps++;
            case (ir[27:26])
                2'b00: begin
                    opB = ir[25] ? {24'b0, ir[7:0]} : regs[ir[3:0]];
                    case (ir[24:21])
                        4'b0000: result = regs[rn] & opB;
                        4'b0010: result = regs[rn] - opB;
                        4'b1100: result = regs[rn] | opB;
                        4'b1101: result = opB;
                        default: result = regs[rn] + opB;
                    endcase
                    if (rd != 4'd15) begin
                        regs[rd] = result;
                    end
                    pcRef = pcRef + 32'd4;
                end
                2'b01: begin
                    addr = regs[rn] + {20'b0, ir[11:0]};
                    if (ir[20]) begin
                        regs[rd] = dmemRef[addr[9:2]];
                    end else begin
                        dmemRef[addr[9:2]] = regs[rd];
                        expAddr.push_back(addr);
                        expData.push_back(regs[rd]);
                    end
                    pcRef = pcRef + 32'd4;
                end
                2'b10: pcRef = pcRef + 32'd8 + {{6{ir[23]}}, ir[23:0], 2'b00};
                default: pcRef = pcRef + 32'd4;
            endcase
        end
    endfunction

    initial begin
        expectedCount = 0;
        @(posedge rstN);
        runReference();
        expectedCount = expAddr.size();
    end

    ////////////////////////////////////////////////////////////
    // Store comparison
    ////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (!rstN) begin
            errorCount    = 0;
            storeCount    = 0;
            settledCycles = 0;
            done          = 1'b0;
        end else if (!done) begin
            if (dataWe) begin
                if (storeCount >= expectedCount) begin
                    $display("Extra store at %0t to address %h", $time, dataAddr);
                    errorCount++;
                end else begin
                    if (dataAddr !== expAddr[storeCount]) begin
                        $display("Error at %0t: dataAddr expected %h, got %h",
                                 $time, expAddr[storeCount], dataAddr);
                        errorCount++;
                    end
                    if (dataWriteData !== expData[storeCount]) begin
                        $display("Error at %0t: dataWriteData expected %h, got %h",
                                 $time, expData[storeCount], dataWriteData);
                        errorCount++;
                    end
                end
                storeCount++;
            end
            // The self-branch keeps fetching its own slot and the two after it
            if (settledCycles > 0 || pc == FinalPc) begin
                if (pc != FinalPc && pc != FinalPc + 32'd4 && pc != FinalPc + 32'd8) begin
                    $display("PC left the final self-branch at %0t: pc %h", $time, pc);
                    errorCount++;
                end
                settledCycles++;
            end
            if (settledCycles == DrainCycles) begin
                if (storeCount != expectedCount) begin
                    $display("Wrong number of stores: expected %0d, saw %0d",
                             expectedCount, storeCount);
                    errorCount++;
                end
                done = 1'b1;
            end
        end
    end

endmodule

// ==== test/tb_armCore.sv ====
`timescale 1ns/1ns

module tb_armCore;

    localparam int ProgWords   = 64;
    localparam int DataWords   = 256;
    localparam int LimitCycles = 4 * ProgWords + 20;

    logic                     CLK;
    logic                     rstN;
    armCorePkg::word_t        instr = '0;
    armCorePkg::word_t        dataRead = '0;
    armCorePkg::word_t        pc;
    armCorePkg::word_t        dataAddr;
    armCorePkg::word_t        dataWriteData;
    logic                     dataWe;

    logic [ProgWords-1:0][31:0] imem;
    logic [DataWords-1:0][31:0] dmem;
    logic [31:0]              lfsrState;
    int                       storeErrors;
    int                       seenStores;
    int                       expectedStores;
    logic                     checksDone;

    armCore i_dut (
        .CLK           (CLK),
        .rstN          (rstN),
        .instr         (instr),
        .dataRead      (dataRead),
        .pc            (pc),
        .dataAddr      (dataAddr),
        .dataWriteData (dataWriteData),
        .dataWe        (dataWe)
    );

    storeChecker i_storeChecker (
        .CLK           (CLK),
        .rstN          (rstN),
        .programImage  (imem),
        .dataImage     (dmem),
        .pc            (pc),
        .dataWe        (dataWe),
        .dataAddr      (dataAddr),
        .dataWriteData (dataWriteData),
        .errorCount    (storeErrors),
        .storeCount    (seenStores),
        .expectedCount (expectedStores),
        .done          (checksDone)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic drawBits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program generator
    ////////////////////////////////////////////////////////////

    task automatic buildProgram();
        logic [31:0] v;
        logic [3:0]  dst;
        logic [3:0]  srcN;
        logic [3:0]  srcM;
        logic [3:0]  cmd;
        logic        immForm;
        logic [7:0]  imm8;
        int          k;
        drawBits(6, v);
        // MOV r0, #base with a word-aligned base
        imem[0] = {4'hE, 3'b001, 4'b1101, 1'b0, 4'd0, 4'd0, 4'd0, v[5:0], 2'b00};
        for (int i = 1; i < ProgWords - 1; i++) begin
            drawBits(3, v);
            dst = (v[2:0] == 3'd0) ? 4'd1 : {1'b0, v[2:0]};
            drawBits(3, v);
            srcN = {1'b0, v[2:0]};
            drawBits(3, v);
            srcM = {1'b0, v[2:0]};
            drawBits(8, v);
            imm8 = v[7:0];
            drawBits(1, v);
            immForm = v[0];
            drawBits(3, v);
            case (v[2:0])
                3'd0:    cmd = 4'b0000;
                3'd1:    cmd = 4'b0010;
                3'd2:    cmd = 4'b0100;
                3'd3:    cmd = 4'b1100;
                default: cmd = 4'b1101;
            endcase
            drawBits(3, v);
            if (v[2:0] == 3'd4) begin
                imem[i] = {4'hE, 4'b0101, 4'b1001, 4'd0, dst, 4'b0, imm8[5:0], 2'b00};
            end else if (v[2:0] == 3'd5) begin
                imem[i] = {4'hE, 4'b0101, 4'b1000, 4'd0, srcM, 4'b0, imm8[5:0], 2'b00};
            end else if (v[2:0] == 3'd6 && i < ProgWords - 3) begin
                // Forward target is i + 2 + k
                k = int'(imm8[1:0]);
                if (k > ProgWords - 3 - i) begin
                    k = ProgWords - 3 - i;
                end
                imem[i] = {4'hE, 4'b1010, 24'(k)};
            end else if (immForm) begin
                imem[i] = {4'hE, 3'b001, cmd, 1'b0, srcN, dst, 4'b0, imm8};
            end else begin
                imem[i] = {4'hE, 3'b000, cmd, 1'b0, srcN, dst, 8'b0, srcM};
            end
        end
        // Branch to itself
        imem[ProgWords-1] = {4'hE, 4'b1010, 24'hFF_FFFE};
    endtask

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    always @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < DataWords; i++) begin
                dmem[i] <= 32'h9E37_79B9 * 32'(i + 1);
            end
        end else if (dataWe) begin
            dmem[dataAddr[9:2]] <= dataWriteData;
        end
        #1;
        instr    = imem[pc[7:2]];
        dataRead = dmem[dataAddr[9:2]];
    end

    initial begin
        rstN      = 1'b0;
        lfsrState = 32'hc4f8;
        buildProgram();
        repeat (5) @(posedge CLK);
        #1 rstN = 1'b1;
        while (!checksDone) @(negedge CLK);
        $display("Errors: %0d, stores seen %0d of %0d",
                 storeErrors, seenStores, expectedStores);
        if (storeErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((5 + LimitCycles) * 100);
        $display("Timeout: program did not finish within %0d cycles", LimitCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule
